// File: verilog/rv_pkg.sv
package rv_pkg;

  // pc, data and register contents
  typedef logic [31:0] word_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  // what the writeback slot holds in a given cycle
  typedef enum logic [1:0] {
    cycle_reset        = 2'd0,
    cycle_no_stall     = 2'd1,
    cycle_taken_branch = 2'd2
  } cycle_status_e;

  // major opcodes of the rv32i base encoding
  localparam opcode_t opcode_lui     = 7'b01_101_11;
  localparam opcode_t opcode_auipc   = 7'b00_101_11;
  localparam opcode_t opcode_branch  = 7'b11_000_11;
  localparam opcode_t opcode_reg_imm = 7'b00_100_11;
  localparam opcode_t opcode_reg_reg = 7'b01_100_11;
  localparam opcode_t opcode_environ = 7'b11_100_11;

  // opcode zero decodes as nothing, so a bubble never writes
  localparam insn_t insn_nop = 32'h0000_0000;

  function automatic reg_idx_t insn_rd(input insn_t insn);
    return insn[11:7];
  endfunction

  function automatic reg_idx_t insn_rs1(input insn_t insn);
    return insn[19:15];
  endfunction

  function automatic reg_idx_t insn_rs2(input insn_t insn);
    return insn[24:20];
  endfunction

  function automatic opcode_t insn_opcode(input insn_t insn);
    return insn[6:0];
  endfunction

endpackage

// File: verilog/insn_mem.sv
`timescale 1ns/1ps

module insn_mem #(
  parameter int imem_words = 256
) (
  input  logic                          clk,
  input  logic                          prog_we,
  input  logic [$clog2(imem_words)-1:0] prog_addr,
  input  rv_pkg::insn_t                 prog_data,
  input  rv_pkg::word_t                 pc,
  output rv_pkg::insn_t                 fetch_insn
);
  import rv_pkg::*;

  typedef logic [$clog2(imem_words)-1:0] prog_addr_t;

  insn_t      mem [imem_words];
  prog_addr_t fetch_idx;

  // pc is a byte address, always word aligned
  assign fetch_idx  = pc[$clog2(imem_words)+1:2];
  assign fetch_insn = mem[fetch_idx];

  // loaded one word per strobe while the core sits in reset
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

endmodule

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  branch_taken,
  input  rv_pkg::word_t         branch_target,
  input  rv_pkg::insn_t         fetch_insn,
  output rv_pkg::word_t         pc,
  output rv_pkg::word_t         d_pc,
  output rv_pkg::insn_t         d_insn,
  output rv_pkg::cycle_status_e d_status
);
  import rv_pkg::*;

  word_t pc_next;

  // branch resolved in execute redirects the next fetch
  assign pc_next = branch_taken ? branch_target : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // the word fetched this cycle is on the wrong path when a branch is taken
  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc     <= '0;
      d_insn   <= insn_nop;
      d_status <= cycle_reset;
    end else if (branch_taken) begin
      d_pc     <= '0;
      d_insn   <= insn_nop;
      d_status <= cycle_taken_branch;
    end else begin
      d_pc     <= pc;
      d_insn   <= fetch_insn;
      d_status <= cycle_no_stall;
    end
  end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  word_t regs [32];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 is cleared by reset and never written, so it reads zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         d_pc,
  input  rv_pkg::insn_t         d_insn,
  input  rv_pkg::cycle_status_e d_status,
  input  logic                  branch_taken,
  input  logic                  wb_we,
  input  rv_pkg::reg_idx_t      wb_rd,
  input  rv_pkg::word_t         wb_data,
  output rv_pkg::reg_idx_t      rs1,
  output rv_pkg::reg_idx_t      rs2,
  input  rv_pkg::word_t         rs1_data,
  input  rv_pkg::word_t         rs2_data,
  output rv_pkg::word_t         x_pc,
  output rv_pkg::insn_t         x_insn,
  output rv_pkg::cycle_status_e x_status,
  output rv_pkg::word_t         x_rs1_val,
  output rv_pkg::word_t         x_rs2_val
);
  import rv_pkg::*;

  word_t rs1_fwd;
  word_t rs2_fwd;

  assign rs1 = insn_rs1(d_insn);
  assign rs2 = insn_rs2(d_insn);

  // the register file takes the writeback value only at the end of this cycle
  assign rs1_fwd = (wb_we && wb_rd != '0 && wb_rd == rs1) ? wb_data : rs1_data;
  assign rs2_fwd = (wb_we && wb_rd != '0 && wb_rd == rs2) ? wb_data : rs2_data;

  // decode holds the instruction right behind a taken branch
  always_ff @(posedge clk) begin
    if (rst) begin
      x_pc     <= '0;
      x_insn   <= insn_nop;
      x_status <= cycle_reset;
    end else if (branch_taken) begin
      x_pc     <= '0;
      x_insn   <= insn_nop;
      x_status <= cycle_taken_branch;
    end else begin
      x_pc     <= d_pc;
      x_insn   <= d_insn;
      x_status <= d_status;
    end
  end

  always_ff @(posedge clk) begin
    x_rs1_val <= rs1_fwd;
    x_rs2_val <= rs2_fwd;
  end

endmodule

// File: verilog/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         x_pc,
  input  rv_pkg::insn_t         x_insn,
  input  rv_pkg::cycle_status_e x_status,
  input  rv_pkg::word_t         x_rs1_val,
  input  rv_pkg::word_t         x_rs2_val,
  input  logic                  wb_we,
  input  rv_pkg::reg_idx_t      wb_rd,
  input  rv_pkg::word_t         wb_data,
  output logic                  branch_taken,
  output rv_pkg::word_t         branch_target,
  output rv_pkg::word_t         m_pc,
  output rv_pkg::insn_t         m_insn,
  output rv_pkg::cycle_status_e m_status,
  output logic                  m_we,
  output rv_pkg::reg_idx_t      m_rd,
  output rv_pkg::word_t         m_data
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  reg_idx_t   src1;
  reg_idx_t   src2;
  word_t      op_a;
  word_t      rs2_val;
  word_t      op_b;
  word_t      imm_i;
  word_t      imm_b;
  logic [4:0] shamt;
  logic       is_reg_reg;
  word_t      sra_out;
  word_t      alu_out;
  word_t      result;
  logic       writes;
  logic       cond;

  assign opcode = insn_opcode(x_insn);
  assign funct3 = x_insn[14:12];
  assign src1   = insn_rs1(x_insn);
  assign src2   = insn_rs2(x_insn);

  assign imm_i = {{20{x_insn[31]}}, x_insn[31:20]};
  assign imm_b = {{20{x_insn[31]}}, x_insn[7], x_insn[30:25], x_insn[11:8], 1'b0};

  // memory holds the younger result, so it wins over writeback
  assign op_a = (m_we && m_rd != '0 && m_rd == src1)    ? m_data  :
                (wb_we && wb_rd != '0 && wb_rd == src1) ? wb_data : x_rs1_val;
  assign rs2_val = (m_we && m_rd != '0 && m_rd == src2)    ? m_data  :
                   (wb_we && wb_rd != '0 && wb_rd == src2) ? wb_data : x_rs2_val;

  assign is_reg_reg = opcode == opcode_reg_reg;
  assign op_b       = is_reg_reg ? rs2_val : imm_i;
  assign shamt      = op_b[4:0];
  assign sra_out    = $signed(op_a) >>> shamt;

  always_comb begin
    case (funct3)
      // bit 30 of an immediate add is just an immediate bit
      3'b000:  alu_out = (is_reg_reg && x_insn[30]) ? op_a - op_b : op_a + op_b;
      3'b001:  alu_out = op_a << shamt;
      3'b010:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      3'b011:  alu_out = {31'd0, op_a < op_b};
      3'b100:  alu_out = op_a ^ op_b;
      3'b101:  alu_out = x_insn[30] ? sra_out : op_a >> shamt;
      3'b110:  alu_out = op_a | op_b;
      default: alu_out = op_a & op_b;
    endcase
  end

  always_comb begin
    writes = 1'b1;
    case (opcode)
      opcode_lui:     result = {x_insn[31:12], 12'd0};
      opcode_auipc:   result = x_pc + {x_insn[31:12], 12'd0};
      opcode_reg_imm,
      opcode_reg_reg: result = alu_out;
      default: begin
        writes = 1'b0;
        result = '0;
      end
    endcase
  end

  // bltu and bgeu compare the raw operands as unsigned
  always_comb begin
    case (funct3)
      3'b000:  cond = op_a == rs2_val;
      3'b001:  cond = op_a != rs2_val;
      3'b100:  cond = $signed(op_a) < $signed(rs2_val);
      3'b101:  cond = $signed(op_a) >= $signed(rs2_val);
      3'b110:  cond = op_a < rs2_val;
      3'b111:  cond = op_a >= rs2_val;
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken  = (opcode == opcode_branch) && cond;
  assign branch_target = x_pc + imm_b;

  // non-writing instructions carry rd and data as zero
  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc     <= '0;
      m_insn   <= insn_nop;
      m_status <= cycle_reset;
      m_we     <= 1'b0;
      m_rd     <= '0;
    end else begin
      m_pc     <= x_pc;
      m_insn   <= x_insn;
      m_status <= x_status;
      m_we     <= writes;
      m_rd     <= writes ? insn_rd(x_insn) : '0;
    end
  end

  always_ff @(posedge clk) begin
    m_data <= result;
  end

endmodule

// File: verilog/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         m_pc,
  input  rv_pkg::insn_t         m_insn,
  input  rv_pkg::cycle_status_e m_status,
  input  logic                  m_we,
  input  rv_pkg::reg_idx_t      m_rd,
  input  rv_pkg::word_t         m_data,
  output logic                  wb_we,
  output rv_pkg::reg_idx_t      wb_rd,
  output rv_pkg::word_t         wb_data,
  output logic                  halt,
  output rv_pkg::word_t         trace_wb_pc,
  output rv_pkg::insn_t         trace_wb_insn,
  output rv_pkg::cycle_status_e trace_wb_status
);
  import rv_pkg::*;

  // no loads, so the memory stage only delays its input by a cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      trace_wb_pc     <= '0;
      trace_wb_insn   <= insn_nop;
      trace_wb_status <= cycle_reset;
      wb_we           <= 1'b0;
      wb_rd           <= '0;
    end else begin
      trace_wb_pc     <= m_pc;
      trace_wb_insn   <= m_insn;
      trace_wb_status <= m_status;
      wb_we           <= m_we;
      wb_rd           <= m_rd;
    end
  end

  always_ff @(posedge clk) begin
    wb_data <= m_data;
  end

  // ecall is the environ encoding with all upper bits zero
  assign halt = (insn_opcode(trace_wb_insn) == opcode_environ) && (trace_wb_insn[31:7] == '0);

endmodule

// File: verilog/rv_processor.sv
`timescale 1ns/1ps

module rv_processor #(
  parameter int imem_words = 256
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          prog_we,
  input  logic [$clog2(imem_words)-1:0] prog_addr,
  input  rv_pkg::insn_t                 prog_data,
  output logic                          halt,
  output rv_pkg::word_t                 trace_wb_pc,
  output rv_pkg::insn_t                 trace_wb_insn,
  output rv_pkg::cycle_status_e         trace_wb_status,
  output logic                          trace_wb_we,
  output rv_pkg::reg_idx_t              trace_wb_rd,
  output rv_pkg::word_t                 trace_wb_data
);
  import rv_pkg::*;

  word_t         pc;
  insn_t         fetch_insn;
  logic          branch_taken;
  word_t         branch_target;
  word_t         d_pc;
  insn_t         d_insn;
  cycle_status_e d_status;
  reg_idx_t      rs1;
  reg_idx_t      rs2;
  word_t         rs1_data;
  word_t         rs2_data;
  word_t         x_pc;
  insn_t         x_insn;
  cycle_status_e x_status;
  word_t         x_rs1_val;
  word_t         x_rs2_val;
  word_t         m_pc;
  insn_t         m_insn;
  cycle_status_e m_status;
  logic          m_we;
  reg_idx_t      m_rd;
  word_t         m_data;

  insn_mem #(.imem_words(imem_words)) imem (
    .clk(clk), .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .pc(pc), .fetch_insn(fetch_insn)
  );

  fetch_stage fetch (
    .clk(clk), .rst(rst), .branch_taken(branch_taken), .branch_target(branch_target),
    .fetch_insn(fetch_insn), .pc(pc),
    .d_pc(d_pc), .d_insn(d_insn), .d_status(d_status)
  );

  // the writeback trace outputs double as the register write port
  reg_file rf (
    .clk(clk), .rst(rst), .we(trace_wb_we), .rd(trace_wb_rd), .rd_data(trace_wb_data),
    .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  decode_stage decode (
    .clk(clk), .rst(rst), .d_pc(d_pc), .d_insn(d_insn), .d_status(d_status),
    .branch_taken(branch_taken),
    .wb_we(trace_wb_we), .wb_rd(trace_wb_rd), .wb_data(trace_wb_data),
    .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .x_pc(x_pc), .x_insn(x_insn), .x_status(x_status),
    .x_rs1_val(x_rs1_val), .x_rs2_val(x_rs2_val)
  );

  execute_unit execute (
    .clk(clk), .rst(rst), .x_pc(x_pc), .x_insn(x_insn), .x_status(x_status),
    .x_rs1_val(x_rs1_val), .x_rs2_val(x_rs2_val),
    .wb_we(trace_wb_we), .wb_rd(trace_wb_rd), .wb_data(trace_wb_data),
    .branch_taken(branch_taken), .branch_target(branch_target),
    .m_pc(m_pc), .m_insn(m_insn), .m_status(m_status),
    .m_we(m_we), .m_rd(m_rd), .m_data(m_data)
  );

  writeback_stage writeback (
    .clk(clk), .rst(rst), .m_pc(m_pc), .m_insn(m_insn), .m_status(m_status),
    .m_we(m_we), .m_rd(m_rd), .m_data(m_data),
    .wb_we(trace_wb_we), .wb_rd(trace_wb_rd), .wb_data(trace_wb_data), .halt(halt),
    .trace_wb_pc(trace_wb_pc), .trace_wb_insn(trace_wb_insn),
    .trace_wb_status(trace_wb_status)
  );

endmodule

// File: include/rv_model.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

localparam int            prog_len   = 40;
localparam rv_pkg::insn_t insn_ecall = 32'h0000_0073;

integer           seed = 32'h1ddb_bf5b;

// generated program and the architectural sequence it retires
rv_pkg::insn_t    prog[$];
rv_pkg::word_t    ret_pc[$];
rv_pkg::insn_t    ret_insn[$];
logic             ret_we[$];
rv_pkg::reg_idx_t ret_rd[$];
rv_pkg::word_t    ret_data[$];
bit               ret_taken[$];

function automatic int rand_below(int n);
  return $unsigned($random(seed)) % n;
endfunction

// x0..x3 only, so most sources hit an instruction still in flight
function automatic rv_pkg::reg_idx_t pick_reg();
  return rv_pkg::reg_idx_t'(rand_below(4));
endfunction

function automatic void gen_program();
  rv_pkg::word_t    r;
  rv_pkg::reg_idx_t rd;
  logic [2:0]       f3;
  logic [6:0]       f7;
  logic [12:0]      off;
  logic [2:0]       br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  prog.delete();
  for (int i = 0; i < prog_len; i++) begin
    r  = $random(seed);
    rd = pick_reg();
    f3 = r[14:12];
    f7 = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, r[30], 5'd0} : 7'd0;
    case (rand_below(7))
      0: prog.push_back({r[31:12], rd, rv_pkg::opcode_lui});
      1: prog.push_back({r[31:12], rd, rv_pkg::opcode_auipc});
      2, 3: begin
        // shifts need a legal upper field, the rest take any immediate
        if (f3 == 3'd1 || f3 == 3'd5) begin
          r[31:25] = (f3 == 3'd5) ? f7 : 7'd0;
        end
        prog.push_back({r[31:20], pick_reg(), f3, rd, rv_pkg::opcode_reg_imm});
      end
      4, 5: prog.push_back({f7, pick_reg(), pick_reg(), f3, rd, rv_pkg::opcode_reg_reg});
      default: begin
        // forward by one to four words, never past the closing ecall
        off = 13'(4 * (1 + rand_below((prog_len - i < 4) ? prog_len - i : 4)));
        prog.push_back({off[12], off[10:5], pick_reg(), pick_reg(), br_f3[rand_below(6)],
                        off[4:1], off[11], rv_pkg::opcode_branch});
      end
    endcase
  end
  prog.push_back(insn_ecall);
endfunction

function automatic rv_pkg::word_t alu_result(rv_pkg::insn_t insn, rv_pkg::word_t a,
                                             rv_pkg::word_t b, bit is_rr);
  case (insn[14:12])
    3'd0: return (is_rr && insn[30]) ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return {31'd0, $signed(a) < $signed(b)};
    3'd3: return {31'd0, a < b};
    3'd4: return a ^ b;
    3'd5: begin
      if (insn[30]) begin
        return $signed(a) >>> b[4:0];
      end
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic bit branch_cond(logic [2:0] f3, rv_pkg::word_t a, rv_pkg::word_t b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    default: return a >= b;
  endcase
endfunction

function automatic void execute_reference();
  rv_pkg::word_t regs [32];
  rv_pkg::word_t pc;
  rv_pkg::word_t a;
  rv_pkg::word_t b;
  rv_pkg::word_t res;
  rv_pkg::insn_t insn;
  bit            we;
  bit            br;
  regs = '{default: '0};
  pc   = '0;
  ret_pc.delete();
  ret_insn.delete();
  ret_we.delete();
  ret_rd.delete();
  ret_data.delete();
  ret_taken.delete();
  do begin
    insn = prog[pc[31:2]];
    a    = regs[rv_pkg::insn_rs1(insn)];
    b    = regs[rv_pkg::insn_rs2(insn)];
    we   = 1'b1;
    br   = 1'b0;
    res  = '0;
    case (rv_pkg::insn_opcode(insn))
      rv_pkg::opcode_lui:     res = {insn[31:12], 12'd0};
      rv_pkg::opcode_auipc:   res = pc + {insn[31:12], 12'd0};
      rv_pkg::opcode_reg_imm: res = alu_result(insn, a, {{20{insn[31]}}, insn[31:20]}, 1'b0);
      rv_pkg::opcode_reg_reg: res = alu_result(insn, a, b, 1'b1);
      default: begin
        we = 1'b0;
        br = (rv_pkg::insn_opcode(insn) == rv_pkg::opcode_branch) &&
             branch_cond(insn[14:12], a, b);
      end
    endcase
    ret_pc.push_back(pc);
    ret_insn.push_back(insn);
    ret_we.push_back(we);
    ret_rd.push_back(we ? rv_pkg::insn_rd(insn) : '0);
    ret_data.push_back(res);
    ret_taken.push_back(br);
    if (we && rv_pkg::insn_rd(insn) != '0) begin
      regs[rv_pkg::insn_rd(insn)] = res;
    end
    pc = br ? pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0}
            : pc + 32'd4;
  end while (insn != insn_ecall);
endfunction

`endif

// File: testbench/tb_rv_processor.sv
`timescale 1ns/1ps

module tb_rv_processor;
  import rv_pkg::*;

  localparam int imem_words      = 256;
  localparam int clk_period      = 4;
  localparam int num_tests       = 5;
  localparam int run_cycles      = 80;
  // reset and load take one cycle per word plus a few around it
  localparam int watchdog_cycles = num_tests * (run_cycles + imem_words + 4);

  logic                          clk;
  logic                          rst;
  logic                          prog_we;
  logic [$clog2(imem_words)-1:0] prog_addr;
  insn_t                         prog_data;
  logic                          halt;
  word_t                         trace_wb_pc;
  insn_t                         trace_wb_insn;
  cycle_status_e                 trace_wb_status;
  logic                          trace_wb_we;
  reg_idx_t                      trace_wb_rd;
  word_t                         trace_wb_data;

  int      check_count;
  int      error_count;
  int      failed_tests;

  `include "rv_model.svh"

  rv_processor #(.imem_words(imem_words)) uut (
    .clk(clk), .rst(rst), .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .halt(halt), .trace_wb_pc(trace_wb_pc), .trace_wb_insn(trace_wb_insn),
    .trace_wb_status(trace_wb_status), .trace_wb_we(trace_wb_we),
    .trace_wb_rd(trace_wb_rd), .trace_wb_data(trace_wb_data)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic word_check(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic insn_check(input string name, input insn_t got, input insn_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic reg_idx_check(input string name, input reg_idx_t got, input reg_idx_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: %s got x%0d expected x%0d", $time, name, got, exp);
    end
  endtask

  task automatic bit_check(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic status_check(input string name, input cycle_status_e got,
                              input cycle_status_e exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  // nothing may leave writeback while the core sits in reset
  task automatic idle_trace_check();
    status_check("trace_wb_status", trace_wb_status, cycle_reset);
    bit_check("halt", halt, 1'b0);
    bit_check("trace_wb_we", trace_wb_we, 1'b0);
  endtask

  // holds reset for the whole load, one word per cycle, ecall past the program
  task automatic load_program();
    @(posedge clk);
    rst     <= 1'b1;
    prog_we <= 1'b0;
    for (int i = 0; i < imem_words; i++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= i[$clog2(imem_words)-1:0];
      prog_data <= (i < prog.size()) ? prog[i] : insn_ecall;
      @(negedge clk);
      idle_trace_check();
    end
    @(posedge clk);
    prog_we <= 1'b0;
    rst     <= 1'b0;
  endtask

  task automatic run_program(input int test);
    int            cycle;
    int            idx;
    int            bubbles;
    int            errs_start;
    int            errs_status;
    int            n_taken;
    int            n_not_taken;
    bit            done;
    cycle_status_e exp_status;
    cycle = 0;
    idx = 0;
    bubbles = 0;
    n_taken = 0;
    n_not_taken = 0;
    done = 1'b0;
    errs_start = error_count;
    while (!done) begin
      @(negedge clk);
      if (bubbles > 0) begin
        exp_status = cycle_taken_branch;
      end else if (idx == 0 && cycle < 4) begin
        exp_status = cycle_reset;
      end else begin
        exp_status = cycle_no_stall;
      end
      errs_status = error_count;
      status_check("trace_wb_status", trace_wb_status, exp_status);
      if (error_count != errs_status) begin
        $display("test %0d: pipeline lost track of the program at retired entry %0d",
                 test, idx);
        done = 1'b1;
      end else if (exp_status == cycle_reset) begin
        idle_trace_check();
      end else if (exp_status == cycle_taken_branch) begin
        insn_check("trace_wb_insn", trace_wb_insn, insn_nop);
        bit_check("trace_wb_we", trace_wb_we, 1'b0);
        bit_check("halt", halt, 1'b0);
        bubbles--;
      end else begin
        word_check("trace_wb_pc", trace_wb_pc, ret_pc[idx]);
        insn_check("trace_wb_insn", trace_wb_insn, ret_insn[idx]);
        bit_check("trace_wb_we", trace_wb_we, ret_we[idx]);
        reg_idx_check("trace_wb_rd", trace_wb_rd, ret_rd[idx]);
        word_check("trace_wb_data", trace_wb_data, ret_data[idx]);
        bit_check("halt", halt, ret_insn[idx] == insn_ecall);
        if (insn_opcode(ret_insn[idx]) == opcode_branch) begin
          // a branch taken by four bytes still squashes the two slots behind it
          if (ret_taken[idx]) begin
            bubbles = 2;
            n_taken++;
          end else begin
            n_not_taken++;
          end
        end
        idx++;
        done = idx == ret_pc.size();
      end
      cycle++;
    end
    if (error_count != errs_start) begin
      failed_tests++;
    end
    $display("test %0d: %0d of %0d retired, %0d taken, %0d not taken, %0d errors",
             test, idx, ret_pc.size(), n_taken, n_not_taken, error_count - errs_start);
  endtask

  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: the final ecall never reached writeback");
    $display("Checks failed");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    check_count  = 0;
    error_count  = 0;
    failed_tests = 0;
    for (int t = 0; t < num_tests; t++) begin
      gen_program();
      execute_reference();
      load_program();
      run_program(t);
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             num_tests, failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+include
verilog/rv_pkg.sv
verilog/insn_mem.sv
verilog/fetch_stage.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_unit.sv
verilog/writeback_stage.sv
verilog/rv_processor.sv
testbench/tb_rv_processor.sv

// File: run_sim.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_rv_processor -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
